//--- logic/mem_pkg.sv
package mem_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Address geometry
   ////////////////////////////////////////////////////////////////////////////

   // Byte address, bit 0 never decoded
   localparam int ADDR_WIDTH     = 12;
   localparam int NUM_BANKS      = 4;
   // Bank select sits just above the byte bit
   localparam int BANK_SEL_WIDTH = 2;
   // Word index inside one bank
   localparam int BANK_IDX_WIDTH = 9;
   localparam int BANK_WORDS     = 2 ** BANK_IDX_WIDTH;
   localparam int DATA_WIDTH     = 16;

   // Read stages inside a bank
   localparam int BANK_READ_LATENCY = 4;
   // Router stage plus bank stages plus merge stage
   localparam int READ_LATENCY      = 1 + BANK_READ_LATENCY + 1;

   ////////////////////////////////////////////////////////////////////////////
   // Request and response types
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } mem_op_e;

   // Top level request
   typedef struct packed {
      logic                  valid;
      mem_op_e               op;
      logic [ADDR_WIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0] wdata;
   } mem_req_t;

   // Per bank request after routing
   typedef struct packed {
      logic                      en;
      logic                      wr;
      logic [BANK_IDX_WIDTH-1:0] idx;
      logic [DATA_WIDTH-1:0]     wdata;
   } bank_req_t;

   // Read data out of one bank, also used as a pipeline stage
   typedef struct packed {
      logic                  valid;
      logic [DATA_WIDTH-1:0] rdata;
   } bank_rsp_t;

   // Top level response, same layout as a bank output
   typedef struct packed {
      logic                  valid;
      logic [DATA_WIDTH-1:0] rdata;
   } mem_rsp_t;

endpackage

//--- logic/mem_req_router.sv
`timescale 1ns/1ps

module mem_req_router
   import mem_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  mem_req_t  req,
   output bank_req_t bank_req [NUM_BANKS]
);

   ////////////////////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////////////////////

   // Low word address bits pick the bank
   logic [BANK_SEL_WIDTH-1:0] sel;
   // Remaining upper bits index the word inside the bank
   logic [BANK_IDX_WIDTH-1:0] idx;

   // Registered request fields
   logic                      en_q [NUM_BANKS];
   logic                      wr_q;
   logic [BANK_IDX_WIDTH-1:0] idx_q;
   logic [DATA_WIDTH-1:0]     wdata_q;

   // Bit 0 skipped, byte lane within a word
   assign sel = req.addr[BANK_SEL_WIDTH:1];
   assign idx = req.addr[ADDR_WIDTH-1:BANK_SEL_WIDTH+1];

   ////////////////////////////////////////////////////////////////////////////
   // Request register
   ////////////////////////////////////////////////////////////////////////////

   // One enable per bank, at most one set
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            en_q[b] <= 1'b0;
         end
      end else begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            en_q[b] <= req.valid && (sel == BANK_SEL_WIDTH'(b));
         end
      end
   end

   // Shared payload, qualified by the bank enables
   always_ff @(posedge clk) begin
      wr_q    <= (req.op == OP_WRITE);
      idx_q   <= idx;
      wdata_q <= req.wdata;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Fan out to the banks
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         bank_req[b].en    = en_q[b];
         // Same write flag, index and data seen by every bank
         bank_req[b].wr    = wr_q;
         bank_req[b].idx   = idx_q;
         bank_req[b].wdata = wdata_q;
      end
   end

endmodule

//--- logic/mem_bank.sv
`timescale 1ns/1ps

module mem_bank
   import mem_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  bank_req_t bank_req,
   output bank_rsp_t bank_rsp
);

   ////////////////////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////////////////////

   // One 16-bit word per index
   logic [DATA_WIDTH-1:0] mem [BANK_WORDS];

   // Read issue decode
   logic                  rd_en;
   logic                  wr_en;
   logic [DATA_WIDTH-1:0] rd_word;

   // Read pipeline, stage 0 nearest the array
   bank_rsp_t             stage [BANK_READ_LATENCY];

   // Contents start cleared
   initial begin
      for (int i = 0; i < BANK_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   assign rd_en = bank_req.en && !bank_req.wr;
   assign wr_en = bank_req.en && bank_req.wr;

   // Write lands on the enable edge
   always @(posedge clk) begin
      if (wr_en) begin
         mem[bank_req.idx] <= bank_req.wdata;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read path
   ////////////////////////////////////////////////////////////////////////////

   // Array read is combinational
   // Zero when no read so idle stages carry no stale data
   assign rd_word = rd_en ? mem[bank_req.idx] : '0;

   // Four registered stages of data plus valid
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < BANK_READ_LATENCY; s++) begin
            stage[s] <= '0;
         end
      end else begin
         stage[0].valid <= rd_en;
         stage[0].rdata <= rd_word;
         for (int s = 1; s < BANK_READ_LATENCY; s++) begin
            stage[s] <= stage[s-1];
         end
      end
   end

   // Several reads in flight at once, one per stage
   // A write in between does not disturb them

   ////////////////////////////////////////////////////////////////////////////
   // Output
   ////////////////////////////////////////////////////////////////////////////

   // Last stage drives the merger
   assign bank_rsp = stage[BANK_READ_LATENCY-1];

endmodule

//--- logic/mem_rsp_merge.sv
`timescale 1ns/1ps

module mem_rsp_merge
   import mem_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  bank_rsp_t bank_rsp [NUM_BANKS],
   output mem_rsp_t  rsp
);

   ////////////////////////////////////////////////////////////////////////////
   // Select
   ////////////////////////////////////////////////////////////////////////////

   // Any bank has read data this cycle
   logic                  any_valid;
   // Data of the chosen bank
   logic [DATA_WIDTH-1:0] sel_data;
   // Priority chain flag
   logic                  found;

   // Router allows only one bank per cycle, so priority order never matters
   // Lowest bank wins anyway
   always_comb begin
      any_valid = 1'b0;
      sel_data  = '0;
      found     = 1'b0;
      for (int b = 0; b < NUM_BANKS; b++) begin
         any_valid = any_valid | bank_rsp[b].valid;
         if (bank_rsp[b].valid && !found) begin
            sel_data = bank_rsp[b].rdata;
            found    = 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Response register
   ////////////////////////////////////////////////////////////////////////////

   // One cycle strobe per read
   always_ff @(posedge clk) begin
      if (rst) begin
         rsp <= '0;
      end else begin
         rsp.valid <= any_valid;
         rsp.rdata <= sel_data;
      end
   end

   // No stall path, consumer takes every strobe

endmodule

//--- logic/mem_banked_top.sv
`timescale 1ns/1ps

module mem_banked_top
   import mem_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  mem_req_t req,
   output mem_rsp_t rsp
);

   ////////////////////////////////////////////////////////////////////////////
   // Internal buses
   ////////////////////////////////////////////////////////////////////////////

   // Routed requests, one per bank
   bank_req_t bank_req [NUM_BANKS];
   // Read data, one per bank
   bank_rsp_t bank_rsp [NUM_BANKS];

   ////////////////////////////////////////////////////////////////////////////
   // Datapath
   ////////////////////////////////////////////////////////////////////////////

   // Stage 1, request register and bank decode
   mem_req_router u_router (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .bank_req (bank_req)
   );

   // Stages 2 to 5, interleaved banks
   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      mem_bank u_bank (
         .clk      (clk),
         .rst      (rst),
         .bank_req (bank_req[b]),
         .bank_rsp (bank_rsp[b])
      );
   end

   // Stage 6, response register
   mem_rsp_merge u_merge (
      .clk      (clk),
      .rst      (rst),
      .bank_rsp (bank_rsp),
      .rsp      (rsp)
   );

endmodule

//--- bench/mem_banked_assert.sv
`timescale 1ns/1ps

module mem_banked_assert
   import mem_pkg::*;
(
   input logic      clk,
   input logic      rst,
   input mem_req_t  req,
   input mem_rsp_t  rsp,
   input bank_rsp_t bank_rsp [NUM_BANKS]
);

   // Read accepted at this edge
   logic                 rd_issue;
   // Output valid of every bank, gathered into one vector
   logic [NUM_BANKS-1:0] bank_valid;

   assign rd_issue = req.valid && (req.op == OP_READ);

   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         bank_valid[b] = bank_rsp[b].valid;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Properties
   ////////////////////////////////////////////////////////////////////////////

   // Response strobe exactly READ_LATENCY edges behind its read, never otherwise
   a_latency : assert property (@(posedge clk) disable iff (rst)
      rsp.valid == $past(rd_issue, READ_LATENCY))
      else $error("rsp.valid does not line up with a read %0d cycles back", READ_LATENCY);

   // Router enables one bank per cycle, so one bank output at most
   a_onehot : assert property (@(posedge clk) disable iff (rst)
      $onehot0(bank_valid))
      else $error("more than one bank output valid in the same cycle");

   // Response register cleared by reset
   a_reset : assert property (@(posedge clk) rst |=> !rsp.valid)
      else $error("rsp.valid high in the cycle after reset");

endmodule

bind mem_banked_top mem_banked_assert u_assert (
   .clk      (clk),
   .rst      (rst),
   .req      (req),
   .rsp      (rsp),
   .bank_rsp (bank_rsp)
);

//--- bench/mem_banked_tb.sv
`timescale 1ns/1ps

module mem_banked_tb
   import mem_pkg::*;
();

   logic     clk;
   logic     rst;
   mem_req_t req;
   mem_rsp_t rsp;

   // Stimulus table, one row per cycle
   mem_req_t stim_req [$];
   string    stim_name [$];

   // Shadow of the whole memory, one entry per 16-bit word
   logic [DATA_WIDTH-1:0] shadow [2**(ADDR_WIDTH-1)];

   // Outstanding reads in issue order
   logic [DATA_WIDTH-1:0] exp_data [$];
   int                    exp_edge [$];
   string                 exp_name [$];

   // Count of rising edges so far
   int cyc = 0;

   int data_errors    = 0;
   int latency_errors = 0;
   int reset_errors   = 0;
   int extra_errors   = 0;
   int missing_errors = 0;

   mem_banked_top uut (
      .clk (clk),
      .rst (rst),
      .req (req),
      .rsp (rsp)
   );

   // 20 ns clock
   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Table construction
   ////////////////////////////////////////////////////////////////////////////

   task automatic add_row(input string name, input mem_op_e op,
                          input logic [ADDR_WIDTH-1:0] addr,
                          input logic [DATA_WIDTH-1:0] wdata);
      mem_req_t row;
      row.valid = 1'b1;
      row.op    = op;
      row.addr  = addr;
      row.wdata = wdata;
      stim_req.push_back(row);
      stim_name.push_back(name);
   endtask

   task automatic add_idle(input string name, input int n);
      mem_req_t row;
      row = '0;
      for (int i = 0; i < n; i++) begin
         stim_req.push_back(row);
         stim_name.push_back(name);
      end
   endtask

   task automatic build_table();
      logic [ADDR_WIDTH-1:0] a;
      mem_op_e               op;
      // Quiet start, nothing may come back
      add_idle("idle", 6);
      // Two words in each bank, bank picked by address bits 2..1
      for (int b = 0; b < 8; b++) begin
         add_row("write_each_bank", OP_WRITE, ADDR_WIDTH'(2 * b), 16'($urandom()));
      end
      // Long enough for a stray response to surface
      add_idle("write_each_bank", READ_LATENCY + 2);
      // Back to back across all banks, twice round
      for (int i = 0; i < 16; i++) begin
         add_row("read_each_bank", OP_READ, ADDR_WIDTH'(2 * (i % 8)), '0);
      end
      // Read right behind a write to the same word
      for (int i = 0; i < 4; i++) begin
         a = ADDR_WIDTH'(64 + 2 * i);
         add_row("write_read_next", OP_WRITE, a, 16'($urandom()));
         add_row("write_read_next", OP_READ, a, '0);
      end
      // Bank 0 only, stride of one full bank row
      for (int k = 0; k < 6; k++) begin
         add_row("bank0_run", OP_WRITE, ADDR_WIDTH'(512 + 8 * k), 16'($urandom()));
      end
      for (int k = 0; k < 8; k++) begin
         add_row("bank0_run", OP_READ, ADDR_WIDTH'(512 + 8 * (k % 6)), '0);
      end
      // Odd and even byte address share a word
      add_row("odd_addr", OP_WRITE, 12'h105, 16'($urandom()));
      add_row("odd_addr", OP_READ, 12'h104, '0);
      add_row("odd_addr", OP_READ, 12'h105, '0);
      add_row("odd_addr", OP_WRITE, 12'h10a, 16'($urandom()));
      add_row("odd_addr", OP_READ, 12'h10b, '0);
      add_row("odd_addr", OP_READ, 12'h10a, '0);
      // Never written, expect zero
      add_row("untouched", OP_READ, 12'h7fe, '0);
      add_row("untouched", OP_READ, 12'hff1, '0);
      // Random mix on a small window so reads hit earlier writes
      for (int i = 0; i < 32; i++) begin
         a  = ADDR_WIDTH'($urandom_range(0, 63));
         op = ($urandom_range(0, 1) == 1) ? OP_WRITE : OP_READ;
         add_row("random_mix", op, a, 16'($urandom()));
      end
      add_idle("tail", 2);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Response monitor
   ////////////////////////////////////////////////////////////////////////////

   // Falling edge, outputs settled
   always @(negedge clk) begin
      logic [DATA_WIDTH-1:0] want;
      int                    want_edge;
      string                 tag;
      if (rst) begin
         if (cyc > 0 && rsp.valid !== 1'b0) begin
            $display("FAIL reset: expected rsp.valid 0, actual %b", rsp.valid);
            reset_errors++;
         end
      end else if (rsp.valid) begin
         if (exp_data.size() == 0) begin
            $display("ERROR: response at cycle %0d with no read outstanding", cyc);
            extra_errors++;
         end else begin
            want      = exp_data.pop_front();
            want_edge = exp_edge.pop_front();
            tag       = exp_name.pop_front();
            if (rsp.rdata !== want) begin
               $display("FAIL %s: expected %h, actual %h", tag, want, rsp.rdata);
               data_errors++;
            end
            if (cyc != want_edge + READ_LATENCY) begin
               $display("FAIL %s latency: expected edge %0d, actual edge %0d",
                        tag, want_edge + READ_LATENCY, cyc);
               latency_errors++;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int       wait_cycles;
      int       total;
      mem_req_t row;
      rst <= 1'b1;
      req <= '0;
      void'($urandom(32'h41774bd6));
      for (int i = 0; i < 2**(ADDR_WIDTH-1); i++) begin
         shadow[i] = '0;
      end
      build_table();

      // Three edges of reset
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      // One row per cycle
      foreach (stim_req[i]) begin
         @(posedge clk);
         row = stim_req[i];
         req <= row;
         if (row.valid && row.op == OP_WRITE) begin
            shadow[row.addr[ADDR_WIDTH-1:1]] = row.wdata;
         end else if (row.valid) begin
            exp_data.push_back(shadow[row.addr[ADDR_WIDTH-1:1]]);
            // cyc lags by one until this edge's update lands
            exp_edge.push_back(cyc + 1);
            exp_name.push_back(stim_name[i]);
         end
      end

      // Drain outstanding reads
      wait_cycles = 0;
      while (exp_data.size() != 0 && wait_cycles < 4 * READ_LATENCY) begin
         @(posedge clk);
         wait_cycles++;
      end
      if (exp_data.size() != 0) begin
         missing_errors = exp_data.size();
         $display("ERROR: %0d read responses never arrived, first one from %s",
                  exp_data.size(), exp_name[0]);
      end

      // Quiet window, a late or extra strobe lands in the monitor
      repeat (READ_LATENCY + 4) @(negedge clk);
      #1;

      total = data_errors + latency_errors + reset_errors + extra_errors + missing_errors;
      $display("Errors: data %0d, latency %0d, reset %0d, extra %0d, missing %0d",
               data_errors, latency_errors, reset_errors, extra_errors, missing_errors);
      if (total == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- flist.f
logic/mem_pkg.sv
logic/mem_req_router.sv
logic/mem_bank.sv
logic/mem_rsp_merge.sv
logic/mem_banked_top.sv
bench/mem_banked_assert.sv
bench/mem_banked_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the banked memory testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
   --top-module mem_banked_tb \
   -f flist.f

# An assertion may stop the model early, so the log decides the outcome
./obj_dir/Vmem_banked_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Result: PASSED" sim.log && ! grep -q "%Error" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi
